/* hw/bp_isa_pkg.sv */
`default_nettype none

package bp_isa_pkg;

    // major opcodes, bits [31:26] of the instruction word.
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,        // register form, see funct field.
        REGIMM  = 6'h01,        // bltz, bgez and the linking variants.
        J       = 6'h02,
        JAL     = 6'h03,
        BEQ     = 6'h04,
        BNE     = 6'h05,
        BLEZ    = 6'h06,
        BGTZ    = 6'h07
    } opcode_e;

    // function codes of SPECIAL, bits [5:0].
    typedef enum logic [5:0] {
        JR   = 6'h08,
        JALR = 6'h09
    } funct_e;

    // what the predictor needs to know about an instruction.
    typedef enum logic [1:0] {
        BR_NONE = 2'd0,         // not a control transfer.
        BR_COND = 2'd1,         // direction decided at run time.
        BR_JUMP = 2'd2          // always taken.
    } branch_class_e;

    // field positions inside the instruction word.
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 26;
    localparam int FUNCT_MSB  = 5;
    localparam int FUNCT_LSB  = 0;

endpackage

`default_nettype wire

/* hw/bp_pred_pkg.sv */
`default_nettype none

package bp_pred_pkg;

    // instruction presented by fetch each cycle.
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
    } fetch_req_t;

    // outcome of the branch held in the memory stage.
    typedef struct packed {
        logic        valid;     // resolve strobe.
        logic [31:0] instr;
        logic [31:0] pc;
        logic        taken;     // actual direction.
        logic [31:0] target;    // resolved address.
    } resolve_t;

    // registered answer handed back to fetch.
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } prediction_t;

    // 2-bit saturating direction counter.
    // the msb alone gives the predicted direction.
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_e;

    // software visible registers.
    typedef enum logic [1:0] {
        CFG_CTRL          = 2'd0,   // bit 0 enable, bit 1 use_pht.
        CFG_PRED_COUNT    = 2'd1,   // taken predictions.
        CFG_RESOLVE_COUNT = 2'd2    // training resolves.
    } cfg_addr_e;

endpackage

`default_nettype wire

/* hw/branch_class_decoder.sv */
`default_nettype none

module branch_class_decoder (
    input  logic [31:0]                 instr,
    output bp_isa_pkg::branch_class_e   branch_class
);

    import bp_isa_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[OPCODE_MSB:OPCODE_LSB];
    assign funct  = instr[FUNCT_MSB:FUNCT_LSB];

    always_comb begin
        branch_class = BR_NONE;
        case (opcode)
            SPECIAL: begin
                // only the register jumps matter here.
                if (funct == JR || funct == JALR) begin
                    branch_class = BR_JUMP;
                end
            end
            REGIMM: begin
                branch_class = BR_COND;     // every regimm form is a branch.
            end
            J, JAL: begin
                branch_class = BR_JUMP;
            end
            BEQ, BNE, BLEZ, BGTZ: begin
                branch_class = BR_COND;
            end
            default: begin
                branch_class = BR_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/target_buffer.sv */
`default_nettype none

module target_buffer #(
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        FLUSH,
    input  logic [31:0] lookup_pc,
    input  logic        write_en,
    input  logic [31:0] write_pc,
    input  logic [31:0] write_target,
    output logic        hit,
    output logic [31:0] target
);

    localparam int ENTRIES  = 1 << BTB_INDEX_BITS;
    localparam int TAG_BITS = 30 - BTB_INDEX_BITS;

    logic [TAG_BITS-1:0]       tag_mem [ENTRIES];
    logic [31:0]               target_mem [ENTRIES];
    logic [ENTRIES-1:0]        valid;

    logic [BTB_INDEX_BITS-1:0] lookup_idx;
    logic [TAG_BITS-1:0]       lookup_tag;
    logic [BTB_INDEX_BITS-1:0] write_idx;
    logic [TAG_BITS-1:0]       write_tag;

    // word index below, tag above.
    assign lookup_idx = lookup_pc[BTB_INDEX_BITS+1:2];
    assign lookup_tag = lookup_pc[31:BTB_INDEX_BITS+2];
    assign write_idx  = write_pc[BTB_INDEX_BITS+1:2];
    assign write_tag  = write_pc[31:BTB_INDEX_BITS+2];

    // read before the edge, so a same-cycle write is not seen.
    assign hit    = valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
    assign target = target_mem[lookup_idx];

    always_ff @(posedge CLK) begin
        if (write_en) begin
            tag_mem[write_idx]    <= write_tag;
            target_mem[write_idx] <= write_target;
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            valid <= '0;
        end else if (FLUSH) begin
            valid <= '0;            // flush wins over a pending write.
        end else if (write_en) begin
            valid[write_idx] <= 1'b1;
        end
    end

    // the resolving stage only ever hands over instruction addresses.
    a_write_aligned: assert property (
        @(posedge CLK) disable iff (!RESET)
        write_en |-> (write_pc[1:0] == 2'b00)
    ) else $error("btb write at unaligned pc %h", write_pc);

endmodule

`default_nettype wire

/* hw/pattern_history_table.sv */
`default_nettype none

module pattern_history_table #(
    parameter int PHT_INDEX_BITS = 6
) (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   FLUSH,
    input  logic [31:0]            lookup_pc,
    input  logic                   update_en,
    input  logic [31:0]            update_pc,
    input  logic                   update_taken,
    output bp_pred_pkg::counter_e  counter
);

    import bp_pred_pkg::*;

    localparam int ENTRIES = 1 << PHT_INDEX_BITS;

    counter_e                  pht [ENTRIES];
    logic [PHT_INDEX_BITS-1:0] lookup_idx;
    logic [PHT_INDEX_BITS-1:0] update_idx;

    // one step toward the observed direction, held at the ends.
    function automatic counter_e step_counter(counter_e cur, logic taken);
        counter_e nxt;
        nxt = cur;
        case (cur)
            STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
            STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
            default:   nxt = WEAK_NT;
        endcase
        return nxt;
    endfunction

    assign lookup_idx = lookup_pc[PHT_INDEX_BITS+1:2];
    assign update_idx = update_pc[PHT_INDEX_BITS+1:2];
    assign counter    = pht[lookup_idx];    // old value on a same-cycle update.

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < ENTRIES; i++) begin
                pht[i] <= WEAK_NT;
            end
        end else if (FLUSH) begin
            for (int i = 0; i < ENTRIES; i++) begin
                pht[i] <= WEAK_NT;
            end
        end else if (update_en) begin
            pht[update_idx] <= step_counter(pht[update_idx], update_taken);
        end
    end

    // every entry was written at reset, so a known pc reads a known state.
    a_counter_known: assert property (
        @(posedge CLK) disable iff (!RESET)
        !$isunknown(lookup_pc) |-> !$isunknown(counter)
    ) else $error("pht counter unknown at pc %h", lookup_pc);

endmodule

`default_nettype wire

/* hw/predictor_config.sv */
`default_nettype none

module predictor_config (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    cfg_write,
    input  bp_pred_pkg::cfg_addr_e  cfg_addr,
    input  logic [31:0]             cfg_wdata,
    output logic [31:0]             cfg_rdata,
    input  logic                    pred_taken_event,
    input  logic                    resolve_event,
    output logic                    predict_enable,
    output logic                    use_pht
);

    import bp_pred_pkg::*;

    logic [31:0] pred_count;
    logic [31:0] resolve_count;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            predict_enable <= 1'b1;
            use_pht        <= 1'b1;
        end else if (cfg_write && cfg_addr == CFG_CTRL) begin
            predict_enable <= cfg_wdata[0];
            use_pht        <= cfg_wdata[1];
        end
    end

    // a write clears the counter, even if an event lands in that cycle.
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            pred_count    <= '0;
            resolve_count <= '0;
        end else begin
            if (cfg_write && cfg_addr == CFG_PRED_COUNT) begin
                pred_count <= '0;
            end else if (pred_taken_event) begin
                pred_count <= pred_count + 32'd1;       // wraps.
            end
            if (cfg_write && cfg_addr == CFG_RESOLVE_COUNT) begin
                resolve_count <= '0;
            end else if (resolve_event) begin
                resolve_count <= resolve_count + 32'd1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            CFG_CTRL:          cfg_rdata = {30'd0, use_pht, predict_enable};
            CFG_PRED_COUNT:    cfg_rdata = pred_count;
            CFG_RESOLVE_COUNT: cfg_rdata = resolve_count;
            default:           cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/bimodal_predictor.sv */
`default_nettype none

module bimodal_predictor #(
    parameter int BTB_INDEX_BITS = 4,
    parameter int PHT_INDEX_BITS = 6
) (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      FLUSH,
    input  bp_pred_pkg::fetch_req_t   fetch,
    input  bp_pred_pkg::resolve_t     resolve,
    input  logic                      predict_enable,
    input  logic                      use_pht,
    output bp_pred_pkg::prediction_t  prediction,
    output logic                      pred_taken_event,
    output logic                      resolve_event
);

    import bp_isa_pkg::*;
    import bp_pred_pkg::*;

    branch_class_e fetch_class;
    branch_class_e resolve_class;
    logic          train;
    logic          btb_write;
    logic          pht_update;
    logic          btb_hit;
    logic [31:0]   btb_target;
    counter_e      pht_counter;
    logic          dir_taken;
    prediction_t   pred_next;

    branch_class_decoder u_fetch_decode (
        .instr        (fetch.instr),
        .branch_class (fetch_class)
    );

    branch_class_decoder u_resolve_decode (
        .instr        (resolve.instr),
        .branch_class (resolve_class)
    );

    // any resolved branch or jump counts as training.
    assign train      = resolve.valid && (resolve_class != BR_NONE);
    assign btb_write  = train && resolve.taken;     // not taken leaves the btb alone.
    assign pht_update = train && (resolve_class == BR_COND);

    target_buffer #(
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) u_btb (
        .CLK          (CLK),
        .RESET        (RESET),
        .FLUSH        (FLUSH),
        .lookup_pc    (fetch.pc),
        .write_en     (btb_write),
        .write_pc     (resolve.pc),
        .write_target (resolve.target),
        .hit          (btb_hit),
        .target       (btb_target)
    );

    pattern_history_table #(
        .PHT_INDEX_BITS (PHT_INDEX_BITS)
    ) u_pht (
        .CLK          (CLK),
        .RESET        (RESET),
        .FLUSH        (FLUSH),
        .lookup_pc    (fetch.pc),
        .update_en    (pht_update),
        .update_pc    (resolve.pc),
        .update_taken (resolve.taken),
        .counter      (pht_counter)
    );

    // jumps always go, branches ask the counter unless it is bypassed.
    always_comb begin
        dir_taken = 1'b0;
        if (fetch_class == BR_JUMP) begin
            dir_taken = 1'b1;
        end else if (fetch_class == BR_COND) begin
            dir_taken = !use_pht || (pht_counter == WEAK_T) || (pht_counter == STRONG_T);
        end
    end

    assign pred_next.taken  = predict_enable && btb_hit && dir_taken;
    assign pred_next.target = btb_hit ? btb_target : 32'd0;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            prediction <= '0;
        end else if (FLUSH) begin
            prediction <= '0;
        end else begin
            prediction <= pred_next;
        end
    end

    assign pred_taken_event = prediction.taken;     // one count per taken cycle.
    assign resolve_event    = train;

    // targets come from taken resolves, which never point at address 0.
    a_taken_target: assert property (
        @(posedge CLK) disable iff (!RESET)
        prediction.taken |-> (prediction.target != 32'd0) && (prediction.target[1:0] == 2'b00)
    ) else $error("taken prediction with bad target %h", prediction.target);

endmodule

`default_nettype wire

/* hw/branch_predict_top.sv */
`default_nettype none

module branch_predict_top #(
    parameter int BTB_INDEX_BITS = 4,       // 16 btb entries.
    parameter int PHT_INDEX_BITS = 6        // 64 counters.
) (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      FLUSH,
    input  bp_pred_pkg::fetch_req_t   fetch,
    input  bp_pred_pkg::resolve_t     resolve,
    output bp_pred_pkg::prediction_t  prediction,
    input  logic                      cfg_write,
    input  bp_pred_pkg::cfg_addr_e    cfg_addr,
    input  logic [31:0]               cfg_wdata,
    output logic [31:0]               cfg_rdata
);

    logic predict_enable;
    logic use_pht;
    logic pred_taken_event;
    logic resolve_event;

    bimodal_predictor #(
        .BTB_INDEX_BITS (BTB_INDEX_BITS),
        .PHT_INDEX_BITS (PHT_INDEX_BITS)
    ) u_predictor (
        .CLK              (CLK),
        .RESET            (RESET),
        .FLUSH            (FLUSH),
        .fetch            (fetch),
        .resolve          (resolve),
        .predict_enable   (predict_enable),
        .use_pht          (use_pht),
        .prediction       (prediction),
        .pred_taken_event (pred_taken_event),
        .resolve_event    (resolve_event)
    );

    predictor_config u_config (
        .CLK              (CLK),
        .RESET            (RESET),
        .cfg_write        (cfg_write),
        .cfg_addr         (cfg_addr),
        .cfg_wdata        (cfg_wdata),
        .cfg_rdata        (cfg_rdata),
        .pred_taken_event (pred_taken_event),
        .resolve_event    (resolve_event),
        .predict_enable   (predict_enable),
        .use_pht          (use_pht)
    );

endmodule

`default_nettype wire

/* bench/tb_branch_predict.sv */
`default_nettype none

module tb_branch_predict;

    timeunit 1ns;
    timeprecision 100ps;

    import bp_isa_pkg::*;
    import bp_pred_pkg::*;

    localparam int BTB_BITS     = 4;
    localparam int PHT_BITS     = 6;
    localparam int RESET_CYCLES = 3;
    localparam int N_ROWS       = 28;
    localparam int N_RANDOM     = 300;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + N_ROWS + N_RANDOM + 40;

    // instruction words used as stimulus.
    localparam logic [31:0] I_BEQ  = {BEQ, 5'd1, 5'd2, 16'h0010};
    localparam logic [31:0] I_BLTZ = {REGIMM, 5'd3, 5'd0, 16'h0008};
    localparam logic [31:0] I_J    = {J, 26'h000_0800};
    localparam logic [31:0] I_JR   = {SPECIAL, 5'd31, 15'd0, JR};
    localparam logic [31:0] I_ADD  = {SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'h20};

    // pc_a and pc_b share btb index 8 with different tags.
    localparam logic [31:0] PC_J  = 32'h0000_1000;
    localparam logic [31:0] T_J   = 32'h0000_2000;
    localparam logic [31:0] PC_BR = 32'h0000_1010;
    localparam logic [31:0] T_BR  = 32'h0000_1100;
    localparam logic [31:0] T_NT  = 32'h0000_1018;
    localparam logic [31:0] PC_A  = 32'h0000_3020;
    localparam logic [31:0] T_A   = 32'h0000_3400;
    localparam logic [31:0] PC_B  = 32'h0000_4020;
    localparam logic [31:0] T_B   = 32'h0000_4400;

    localparam resolve_t    NO_RES  = '0;
    localparam prediction_t P_MISS  = '0;
    localparam prediction_t P_J_T   = {1'b1, T_J};
    localparam prediction_t P_J_NT  = {1'b0, T_J};
    localparam prediction_t P_BR_T  = {1'b1, T_BR};
    localparam prediction_t P_BR_NT = {1'b0, T_BR};
    localparam prediction_t P_A_T   = {1'b1, T_A};
    localparam prediction_t P_B_T   = {1'b1, T_B};
    localparam prediction_t P_B_NT  = {1'b0, T_B};

    typedef enum logic [2:0] {
        ACT_NONE,
        ACT_FLUSH,
        ACT_CTRL_OFF,       // enable 0, use_pht 1.
        ACT_CTRL_ON,        // enable 1, use_pht 1.
        ACT_CTRL_NO_PHT     // enable 1, use_pht 0.
    } action_e;

    typedef struct packed {
        fetch_req_t  req;
        resolve_t    res;
        action_e     act;
        prediction_t exp;
    } row_t;

    logic        CLK = 1'b0;
    logic        RESET;
    logic        FLUSH;
    fetch_req_t  fetch;
    resolve_t    resolve;
    prediction_t prediction;
    logic        cfg_write;
    cfg_addr_e   cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;

    row_t        rows [N_ROWS];
    int          n_rows = 0;
    int          error_count = 0;
    int          cycle_count = 0;
    int          exp_pred_count = 0;
    int          exp_resolve_count = 0;
    logic [31:0] rng_state = 32'd7;

    // reference copy of the tables.
    logic        m_valid [1 << BTB_BITS];
    logic [31:0] m_pc [1 << BTB_BITS];
    logic [31:0] m_target [1 << BTB_BITS];
    counter_e    m_count [1 << PHT_BITS];

    branch_predict_top #(
        .BTB_INDEX_BITS (BTB_BITS),
        .PHT_INDEX_BITS (PHT_BITS)
    ) dut0 (
        .CLK        (CLK),
        .RESET      (RESET),
        .FLUSH      (FLUSH),
        .fetch      (fetch),
        .resolve    (resolve),
        .prediction (prediction),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata)
    );

    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("the run timed out after %0d cycles without finishing", cycle_count);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_prediction(prediction_t got, prediction_t exp, string where);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s prediction %0b/%h, expected %0b/%h",
                     $time, where, got.taken, got.target, exp.taken, exp.target);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(logic [31:0] got, logic [31:0] exp, string where);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s read %h, expected %h", $time, where, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // class from the opcode and, for register jumps, the function field.
    function automatic branch_class_e class_of(logic [31:0] instr);
        case (instr[31:26])
            J, JAL:                       return BR_JUMP;
            BEQ, BNE, BLEZ, BGTZ, REGIMM: return BR_COND;
            SPECIAL:  return (instr[5:0] == JR || instr[5:0] == JALR) ? BR_JUMP : BR_NONE;
            default:                      return BR_NONE;
        endcase
    endfunction

    function automatic fetch_req_t fetched(logic [31:0] instr, logic [31:0] pc);
        return {instr, pc};
    endfunction

    function automatic resolve_t outcome(logic [31:0] instr, logic [31:0] pc,
                                         logic taken, logic [31:0] target);
        return {1'b1, instr, pc, taken, target};
    endfunction

    task automatic model_clear();
        for (int i = 0; i < (1 << BTB_BITS); i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < (1 << PHT_BITS); i++) begin
            m_count[i] = WEAK_NT;
        end
    endtask

    // prediction for enable and use_pht both set.
    function automatic prediction_t model_predict(fetch_req_t f);
        prediction_t   p;
        int            bi;
        logic          hit;
        branch_class_e c;
        counter_e      cnt;
        bi  = int'(f.pc[BTB_BITS+1:2]);
        hit = m_valid[bi] && (m_pc[bi][31:BTB_BITS+2] == f.pc[31:BTB_BITS+2]);
        c   = class_of(f.instr);
        cnt = m_count[int'(f.pc[PHT_BITS+1:2])];
        p.target = hit ? m_target[bi] : 32'd0;
        p.taken  = hit && (c == BR_JUMP ||
                   (c == BR_COND && (cnt == WEAK_T || cnt == STRONG_T)));
        return p;
    endfunction

    task automatic model_train(resolve_t r);
        branch_class_e c;
        int            bi;
        int            pi;
        c  = class_of(r.instr);
        bi = int'(r.pc[BTB_BITS+1:2]);
        pi = int'(r.pc[PHT_BITS+1:2]);
        if (r.valid && c != BR_NONE) begin
            if (r.taken) begin
                m_valid[bi]  = 1'b1;
                m_pc[bi]     = r.pc;
                m_target[bi] = r.target;
            end
            if (c == BR_COND) begin
                if (r.taken && m_count[pi] != STRONG_T) begin
                    m_count[pi] = counter_e'(m_count[pi] + 2'd1);
                end else if (!r.taken && m_count[pi] != STRONG_NT) begin
                    m_count[pi] = counter_e'(m_count[pi] - 2'd1);
                end
            end
        end
    endtask

    task automatic add_row(fetch_req_t f, resolve_t r, action_e act, prediction_t exp);
        rows[n_rows] = {f, r, act, exp};
        n_rows++;
    endtask

    // expected values hold the tables as they were before the row's own resolve.
    task automatic build_table();
        add_row(fetched(I_J, PC_J), NO_RES, ACT_NONE, P_MISS);      // empty btb.
        add_row(fetched(I_BEQ, PC_BR), NO_RES, ACT_NONE, P_MISS);
        add_row(fetched(I_ADD, 32'd0), outcome(I_J, PC_J, 1'b1, T_J), ACT_NONE, P_MISS);
        add_row(fetched(I_J, PC_J), NO_RES, ACT_NONE, P_J_T);
        add_row(fetched(I_ADD, PC_J), NO_RES, ACT_NONE, P_J_NT);
        add_row(fetched(I_BEQ, PC_BR), outcome(I_BEQ, PC_BR, 1'b1, T_BR), ACT_NONE, P_MISS);
        add_row(fetched(I_BEQ, PC_BR), outcome(I_BEQ, PC_BR, 1'b1, T_BR), ACT_NONE, P_BR_T);
        add_row(fetched(I_BEQ, PC_BR), outcome(I_BEQ, PC_BR, 1'b1, T_BR), ACT_NONE, P_BR_T);
        add_row(fetched(I_BEQ, PC_BR), outcome(I_BEQ, PC_BR, 1'b0, T_NT), ACT_NONE, P_BR_T);
        add_row(fetched(I_BEQ, PC_BR), outcome(I_BEQ, PC_BR, 1'b0, T_NT), ACT_NONE, P_BR_T);
        add_row(fetched(I_BEQ, PC_BR), outcome(I_BEQ, PC_BR, 1'b0, T_NT), ACT_NONE, P_BR_NT);
        add_row(fetched(I_BEQ, PC_BR), outcome(I_BEQ, PC_BR, 1'b1, T_BR), ACT_NONE, P_BR_NT);
        add_row(fetched(I_BEQ, PC_BR), NO_RES, ACT_NONE, P_BR_NT);  // back at weak nt.
        add_row(fetched(I_ADD, 32'd0), outcome(I_J, PC_A, 1'b1, T_A), ACT_NONE, P_MISS);
        add_row(fetched(I_J, PC_A), outcome(I_J, PC_B, 1'b1, T_B), ACT_NONE, P_A_T);
        add_row(fetched(I_J, PC_A), NO_RES, ACT_NONE, P_MISS);       // replaced by pc_b.
        add_row(fetched(I_J, PC_B), NO_RES, ACT_NONE, P_B_T);
        add_row(fetched(I_J, PC_J), NO_RES, ACT_CTRL_OFF, P_J_T);
        add_row(fetched(I_J, PC_J), NO_RES, ACT_NONE, P_J_NT);
        add_row(fetched(I_J, PC_B), NO_RES, ACT_CTRL_ON, P_B_NT);
        add_row(fetched(I_BEQ, PC_BR), NO_RES, ACT_CTRL_NO_PHT, P_BR_NT);
        add_row(fetched(I_BEQ, PC_BR), NO_RES, ACT_NONE, P_BR_T);
        add_row(fetched(I_BEQ, PC_BR), NO_RES, ACT_CTRL_ON, P_BR_T);
        // leaves the counter at strong nt before the flush.
        add_row(fetched(I_BEQ, PC_BR), outcome(I_BEQ, PC_BR, 1'b0, T_NT), ACT_NONE, P_BR_NT);
        add_row(fetched(I_J, PC_J), NO_RES, ACT_FLUSH, P_MISS);
        add_row(fetched(I_J, PC_J), outcome(I_BEQ, PC_BR, 1'b1, T_BR), ACT_NONE, P_MISS);
        add_row(fetched(I_BEQ, PC_BR), NO_RES, ACT_NONE, P_BR_T);  // weak nt plus one.
        add_row(fetched(I_ADD, 32'd0), NO_RES, ACT_FLUSH, P_MISS);
    endtask

    // called on a falling edge, returns on the next one.
    task automatic run_cycle(fetch_req_t f, resolve_t r, action_e act, prediction_t exp,
                             string where);
        fetch     = f;
        resolve   = r;
        FLUSH     = (act == ACT_FLUSH);
        cfg_write = (act == ACT_CTRL_OFF || act == ACT_CTRL_ON || act == ACT_CTRL_NO_PHT);
        cfg_addr  = CFG_CTRL;
        case (act)
            ACT_CTRL_OFF:    cfg_wdata = 32'd2;
            ACT_CTRL_NO_PHT: cfg_wdata = 32'd1;
            default:         cfg_wdata = 32'd3;
        endcase
        if (r.valid && class_of(r.instr) != BR_NONE) begin
            exp_resolve_count++;
        end
        @(negedge CLK);
        check_prediction(prediction, exp, where);
        if (exp.taken) begin
            exp_pred_count++;       // counted at the following edge.
        end
        FLUSH     = 1'b0;
        cfg_write = 1'b0;
    endtask

    function automatic logic [31:0] pick_instr(logic [2:0] sel);
        case (sel)
            3'd0, 3'd1, 3'd2: return I_BEQ;
            3'd3:             return I_BLTZ;
            3'd4:             return I_J;
            3'd5:             return I_JR;
            default:          return I_ADD;
        endcase
    endfunction

    // 128 word addresses, so btb and pht entries alias often.
    function automatic logic [31:0] random_pc(logic [6:0] w);
        return 32'h0001_0000 | {23'd0, w, 2'b00};
    endfunction

    task automatic random_step(int n);
        logic [31:0] a;
        logic [31:0] b;
        fetch_req_t  f;
        resolve_t    r;
        prediction_t e;
        rng_state = xorshift32(rng_state);
        a = rng_state;
        rng_state = xorshift32(rng_state);
        b = rng_state;
        f = fetched(pick_instr(a[2:0]), random_pc(a[15:9]));
        r = outcome(pick_instr(b[2:0]), random_pc(b[15:9]), b[3],
                    32'h0002_0000 | {20'd0, b[25:16], 2'b00});
        if (class_of(r.instr) == BR_JUMP) begin
            r.taken = 1'b1;
        end
        r.valid = (b[5:4] != 2'b00);
        e = model_predict(f);       // fetch sees the tables before this resolve.
        model_train(r);
        run_cycle(f, r, ACT_NONE, e, $sformatf("random step %0d", n));
    endtask

    task automatic read_and_check(cfg_addr_e addr, logic [31:0] exp, string where);
        cfg_addr = addr;
        #10;
        check_reg(cfg_rdata, exp, where);
        @(negedge CLK);
    endtask

    initial begin
        fetch_req_t idle;
        RESET     = 1'b0;
        FLUSH     = 1'b0;
        fetch     = '0;
        resolve   = '0;
        cfg_write = 1'b0;
        cfg_addr  = CFG_CTRL;
        cfg_wdata = '0;
        idle      = fetched(I_ADD, 32'd0);
        model_clear();
        build_table();
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            run_cycle(rows[i].req, rows[i].res, rows[i].act, rows[i].exp,
                      $sformatf("row %0d", i));
        end
        // the last rows flushed the tables, so the model starts clean.
        for (int i = 0; i < N_RANDOM; i++) begin
            random_step(i);
        end
        repeat (2) run_cycle(idle, NO_RES, ACT_NONE, model_predict(idle), "idle");
        read_and_check(CFG_CTRL, 32'd3, "ctrl register");
        read_and_check(CFG_PRED_COUNT, exp_pred_count, "prediction count");
        read_and_check(CFG_RESOLVE_COUNT, exp_resolve_count, "resolve count");
        cfg_write = 1'b1;
        cfg_addr  = CFG_PRED_COUNT;
        @(negedge CLK);
        cfg_write = 1'b0;
        read_and_check(CFG_PRED_COUNT, 32'd0, "cleared prediction count");
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

/* files.f */
hw/bp_isa_pkg.sv
hw/bp_pred_pkg.sv
hw/branch_class_decoder.sv
hw/target_buffer.sv
hw/pattern_history_table.sv
hw/predictor_config.sv
hw/bimodal_predictor.sv
hw/branch_predict_top.sv
bench/tb_branch_predict.sv

/* Bender.yml */
package:
  name: branch_predict

sources:
  - files:
      - hw/bp_isa_pkg.sv
      - hw/bp_pred_pkg.sv
      - hw/branch_class_decoder.sv
      - hw/target_buffer.sv
      - hw/pattern_history_table.sv
      - hw/predictor_config.sv
      - hw/bimodal_predictor.sv
      - hw/branch_predict_top.sv
  - target: test
    files:
      - bench/tb_branch_predict.sv
